// File: hw/redmule_pkg.sv
// ============================================================
// Data widths, element, bias, accumulator and result types,
// default array sizes of the matrix-vector engine
// ============================================================

package redmule_pkg;

  // Default array geometry
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned ARRAY_WIDTH  = 4;

  // Operand widths
  localparam int unsigned ELEM_W = 8;
  localparam int unsigned BIAS_W = 16;

  // Row sum holds Height 16-bit products plus the bias
  localparam int unsigned ACC_W = 20;

  // Saturated result width
  localparam int unsigned Z_W = 16;

  // X and W element
  typedef logic signed [ELEM_W-1:0] elem_t;

  // Per-row bias (Y)
  typedef logic signed [BIAS_W-1:0] bias_t;

  // Row dot product plus bias
  typedef logic signed [ACC_W-1:0] acc_t;

  // Z value after saturation
  typedef logic signed [Z_W-1:0] z_t;

endpackage : redmule_pkg

// File: hw/redmule_cfg_pkg.sv
// ============================================================
// Register map and register write port types
// ============================================================

package redmule_cfg_pkg;

  // Register port
  typedef logic [7:0]  cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  // Number of W vectors in one job
  typedef logic [7:0] job_len_t;

  // X element (r, c) at REG_X_BASE + r * Height + c, data bits [7:0]
  localparam cfg_addr_t REG_X_BASE = 8'h00;

  // Bias r at REG_Y_BASE + r, data bits [15:0]
  localparam cfg_addr_t REG_Y_BASE = 8'h40;

  // Job start, data bits [7:0] hold the vector count
  localparam cfg_addr_t REG_START = 8'h54;

endpackage : redmule_cfg_pkg

// File: hw/redmule_decoder.sv
// ============================================================
// Register write decoder with X tile and bias storage,
// job start and W vector acceptance
// ============================================================
`timescale 1ns/1ps

module redmule_decoder #(
  parameter int unsigned Height = redmule_pkg::ARRAY_HEIGHT,
  parameter int unsigned Width  = redmule_pkg::ARRAY_WIDTH
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  logic                                      cfg_valid_i,
  input  redmule_cfg_pkg::cfg_addr_t                cfg_addr_i,
  input  redmule_cfg_pkg::cfg_data_t                cfg_data_i,
  input  logic                                      w_valid_i,
  input  logic                                      job_done_i,
  output redmule_pkg::elem_t [Width-1:0][Height-1:0] x_tile_o,
  output redmule_pkg::bias_t [Width-1:0]            y_bias_o,
  output logic                                      w_accept_o,
  output logic                                      job_start_o,
  output redmule_cfg_pkg::job_len_t                 job_len_o,
  output logic                                      busy_o
);
  import redmule_pkg::*;
  import redmule_cfg_pkg::*;

  elem_t [Width-1:0][Height-1:0] x_tile_q;
  bias_t [Width-1:0]             y_bias_q;
  logic                          busy_q;
  logic                          job_start_q;
  job_len_t                      job_len_q;
  job_len_t                      w_cnt_q;
  logic                          cfg_write;
  logic                          start_hit;

  // Configuration is only taken while no job runs
  assign cfg_write = cfg_valid_i & ~busy_q;
  assign start_hit = cfg_write && (cfg_addr_i == REG_START) &&
                     (cfg_data_i[$bits(job_len_t)-1:0] != '0);

  // X tile and bias registers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_tile_q <= '0;
      y_bias_q <= '0;
    end else if (cfg_write) begin
      for (int r = 0; r < Width; r++) begin
        for (int c = 0; c < Height; c++) begin
          if (cfg_addr_i == cfg_addr_t'(REG_X_BASE + r * Height + c)) begin
            x_tile_q[r][c] <= cfg_data_i[ELEM_W-1:0];
          end
        end
        if (cfg_addr_i == cfg_addr_t'(REG_Y_BASE + r)) begin
          y_bias_q[r] <= cfg_data_i[BIAS_W-1:0];
        end
      end
    end
  end

  // Job control and accepted vector count
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      job_start_q <= 1'b0;
      job_len_q   <= '0;
      w_cnt_q     <= '0;
    end else begin
      job_start_q <= start_hit;
      if (start_hit) begin
        busy_q    <= 1'b1;
        job_len_q <= cfg_data_i[$bits(job_len_t)-1:0];
        w_cnt_q   <= '0;
      end else begin
        if (job_done_i) begin
          busy_q <= 1'b0;
        end
        if (w_accept_o) begin
          w_cnt_q <= w_cnt_q + 1'b1;
        end
      end
    end
  end

  // Strobes past the job's count are dropped
  assign w_accept_o  = w_valid_i & busy_q & (w_cnt_q < job_len_q);

  assign x_tile_o    = x_tile_q;
  assign y_bias_o    = y_bias_q;
  assign job_start_o = job_start_q;
  assign job_len_o   = job_len_q;
  assign busy_o      = busy_q;

  // A job ends only after all of its vectors were taken in
  a_done_after_all_w : assert property (
    @(posedge clk_i) disable iff (rst_i)
    job_done_i |-> (busy_q && w_cnt_q == job_len_q)
  ) else $error("job done before all W vectors were accepted");

  a_accept_busy : assert property (
    @(posedge clk_i) disable iff (rst_i)
    w_accept_o |-> busy_o
  ) else $error("W vector accepted while idle");

endmodule : redmule_decoder

// File: hw/redmule_row.sv
// ============================================================
// One engine row: Height multipliers, product register,
// registered sum plus bias
// ============================================================
`timescale 1ns/1ps

module redmule_row #(
  parameter int unsigned Height = redmule_pkg::ARRAY_HEIGHT
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  redmule_pkg::elem_t [Height-1:0] x_row_i,
  input  redmule_pkg::elem_t [Height-1:0] w_vec_i,
  input  redmule_pkg::bias_t              bias_i,
  output redmule_pkg::acc_t               acc_o
);
  import redmule_pkg::*;

  // Full-precision product of two elements
  typedef logic signed [2*ELEM_W-1:0] prod_t;

  prod_t [Height-1:0] prod_q;
  acc_t               sum_d;
  acc_t               sum_q;

  // Stage one
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prod_q <= '0;
    end else begin
      for (int h = 0; h < Height; h++) begin
        prod_q[h] <= x_row_i[h] * w_vec_i[h];
      end
    end
  end

  // Sign-extended adder tree, bias folded in
  always_comb begin
    sum_d = acc_t'(bias_i);
    for (int h = 0; h < Height; h++) begin
      sum_d = sum_d + acc_t'(prod_q[h]);
    end
  end

  // Stage two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sum_q <= '0;
    end else begin
      sum_q <= sum_d;
    end
  end

  assign acc_o = sum_q;

endmodule : redmule_row

// File: hw/redmule_engine.sv
// ============================================================
// Multiply-accumulate engine: Width rows sharing one W vector,
// two-stage valid pipeline
// ============================================================
`timescale 1ns/1ps

module redmule_engine #(
  parameter int unsigned Height = redmule_pkg::ARRAY_HEIGHT,
  parameter int unsigned Width  = redmule_pkg::ARRAY_WIDTH
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  redmule_pkg::elem_t [Width-1:0][Height-1:0] x_tile_i,
  input  redmule_pkg::bias_t [Width-1:0]            y_bias_i,
  input  redmule_pkg::elem_t [Height-1:0]           w_vec_i,
  input  logic                                      w_accept_i,
  output logic                                      acc_valid_o,
  output redmule_pkg::acc_t [Width-1:0]             acc_vec_o
);

  // One bit per row pipeline stage
  logic [1:0] valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[0], w_accept_i};
    end
  end

  assign acc_valid_o = valid_q[1];

  // Every row sees the same W vector
  for (genvar r = 0; r < Width; r++) begin : gen_rows
    redmule_row #(
      .Height ( Height )
    ) i_row (
      .clk_i   ( clk_i        ),
      .rst_i   ( rst_i        ),
      .x_row_i ( x_tile_i[r]  ),
      .w_vec_i ( w_vec_i      ),
      .bias_i  ( y_bias_i[r]  ),
      .acc_o   ( acc_vec_o[r] )
    );
  end

endmodule : redmule_engine

// File: hw/redmule_z_buffer.sv
// ============================================================
// Z buffer: saturation to 16 bits, output register,
// result counting and end-of-job event
// ============================================================
`timescale 1ns/1ps

module redmule_z_buffer #(
  parameter int unsigned Width = redmule_pkg::ARRAY_WIDTH
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          acc_valid_i,
  input  redmule_pkg::acc_t [Width-1:0] acc_vec_i,
  input  logic                          job_start_i,
  input  redmule_cfg_pkg::job_len_t     job_len_i,
  output logic                          z_valid_o,
  output redmule_pkg::z_t [Width-1:0]   z_vec_o,
  output logic                          evt_o,
  output logic                          job_done_o
);
  import redmule_pkg::*;
  import redmule_cfg_pkg::*;

  // Limits of z_t seen at accumulator width
  localparam acc_t Z_MAX = acc_t'(2 ** (Z_W - 1) - 1);
  localparam acc_t Z_MIN = acc_t'(-(2 ** (Z_W - 1)));

  z_t [Width-1:0] z_vec_q;
  logic           z_valid_q;
  logic           evt_q;
  job_len_t       res_cnt_q;
  job_len_t       res_cnt_d;

  function automatic z_t saturate(acc_t acc);
    z_t res;
    if (acc > Z_MAX) begin
      res = z_t'(Z_MAX);
    end else if (acc < Z_MIN) begin
      res = z_t'(Z_MIN);
    end else begin
      res = z_t'(acc);
    end
    return res;
  endfunction

  // Result payload
  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      for (int r = 0; r < Width; r++) begin
        z_vec_q[r] <= saturate(acc_vec_i[r]);
      end
    end
  end

  assign res_cnt_d = res_cnt_q + 1'b1;

  // Strobe, result count and last-result event
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      z_valid_q <= 1'b0;
      evt_q     <= 1'b0;
      res_cnt_q <= '0;
    end else begin
      z_valid_q <= acc_valid_i;
      evt_q     <= acc_valid_i && (res_cnt_d == job_len_i);
      if (job_start_i) begin
        res_cnt_q <= '0;
      end else if (acc_valid_i) begin
        res_cnt_q <= res_cnt_d;
      end
    end
  end

  assign z_valid_o  = z_valid_q;
  assign z_vec_o    = z_vec_q;
  assign evt_o      = evt_q;
  assign job_done_o = evt_q;

  a_evt_with_z : assert property (
    @(posedge clk_i) disable iff (rst_i)
    evt_o |-> z_valid_o
  ) else $error("event raised without a Z vector");

endmodule : redmule_z_buffer

// File: hw/redmule_top.sv
// ============================================================
// Accelerator top level: register decoder, engine, Z buffer
// ============================================================
`timescale 1ns/1ps

module redmule_top #(
  parameter int unsigned Height = redmule_pkg::ARRAY_HEIGHT,
  parameter int unsigned Width  = redmule_pkg::ARRAY_WIDTH
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            cfg_valid_i,
  input  redmule_cfg_pkg::cfg_addr_t      cfg_addr_i,
  input  redmule_cfg_pkg::cfg_data_t      cfg_data_i,
  input  logic                            w_valid_i,
  input  redmule_pkg::elem_t [Height-1:0] w_vec_i,
  output logic                            z_valid_o,
  output redmule_pkg::z_t [Width-1:0]     z_vec_o,
  output logic                            evt_o,
  output logic                            busy_o
);
  import redmule_pkg::*;
  import redmule_cfg_pkg::*;

  elem_t [Width-1:0][Height-1:0] x_tile;
  bias_t [Width-1:0]             y_bias;
  acc_t  [Width-1:0]             acc_vec;
  job_len_t                      job_len;
  logic                          w_accept;
  logic                          job_start;
  logic                          job_done;
  logic                          acc_valid;

  redmule_decoder #(
    .Height ( Height ),
    .Width  ( Width  )
  ) i_decoder (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .cfg_valid_i ( cfg_valid_i ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_data_i  ( cfg_data_i  ),
    .w_valid_i   ( w_valid_i   ),
    .job_done_i  ( job_done    ),
    .x_tile_o    ( x_tile      ),
    .y_bias_o    ( y_bias      ),
    .w_accept_o  ( w_accept    ),
    .job_start_o ( job_start   ),
    .job_len_o   ( job_len     ),
    .busy_o      ( busy_o      )
  );

  // W vector goes straight to the rows, qualified by w_accept
  redmule_engine #(
    .Height ( Height ),
    .Width  ( Width  )
  ) i_engine (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .x_tile_i    ( x_tile    ),
    .y_bias_i    ( y_bias    ),
    .w_vec_i     ( w_vec_i   ),
    .w_accept_i  ( w_accept  ),
    .acc_valid_o ( acc_valid ),
    .acc_vec_o   ( acc_vec   )
  );

  redmule_z_buffer #(
    .Width ( Width )
  ) i_z_buffer (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .acc_valid_i ( acc_valid ),
    .acc_vec_i   ( acc_vec   ),
    .job_start_i ( job_start ),
    .job_len_i   ( job_len   ),
    .z_valid_o   ( z_valid_o ),
    .z_vec_o     ( z_vec_o   ),
    .evt_o       ( evt_o     ),
    .job_done_o  ( job_done  )
  );

endmodule : redmule_top

// File: testbench/tb_clock.sv
// ============================================================
// Testbench clock source, 100 ns period
// ============================================================
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  localparam int HALF_PERIOD_NS = 50;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule : tb_clock

// File: testbench/redmule_checker.sv
// ============================================================
// Testbench checker: reference model of X, biases and jobs,
// Z vector and event comparison, per-test report
// ============================================================
`timescale 1ns/1ps

module redmule_checker (
  input  logic                                                     clk_i,
  input  logic                                                     rst_i,
  input  logic                                                     cfg_valid_i,
  input  redmule_cfg_pkg::cfg_addr_t                               cfg_addr_i,
  input  redmule_cfg_pkg::cfg_data_t                               cfg_data_i,
  input  logic                                                     w_valid_i,
  input  logic [redmule_pkg::ARRAY_HEIGHT*redmule_pkg::ELEM_W-1:0] w_vec_i,
  input  logic                                                     z_valid_i,
  input  logic [redmule_pkg::ARRAY_WIDTH*redmule_pkg::Z_W-1:0]     z_vec_i,
  input  logic                                                     evt_i,
  input  logic                                                     busy_i,
  output int                                                       err_cnt_o
);
  import redmule_pkg::*;
  import redmule_cfg_pkg::*;

  localparam int ROWS    = ARRAY_WIDTH;
  localparam int COLS    = ARRAY_HEIGHT;
  localparam int ZV_W    = ROWS * Z_W;
  localparam int LATENCY = 3;
  localparam int Z_HI    = 2 ** (Z_W - 1) - 1;
  localparam int Z_LO    = -(2 ** (Z_W - 1));

  // Model state
  int x_m [ROWS][COLS];
  int y_m [ROWS];
  bit busy_m;
  bit job_over;
  int len_m;
  int cnt_m;
  int cyc;
  int rst_cyc;

  // Expected Z vectors, oldest first
  logic [ZV_W-1:0] exp_z_q [$];
  int              exp_cyc_q [$];
  bit              exp_last_q [$];

  string cur_test = "none";
  int    test_errs;
  int    test_z;
  int    total_errs;
  int    total_z;
  int    tests_run;
  int    tests_failed;

  assign err_cnt_o = total_errs;

  // Row dot product plus bias, clipped to the signed 16-bit range
  function automatic logic [ZV_W-1:0] expect_z(input logic [COLS*ELEM_W-1:0] w);
    logic [ZV_W-1:0] res;
    int              acc;
    int              wv;
    for (int r = 0; r < ROWS; r++) begin
      acc = y_m[r];
      for (int c = 0; c < COLS; c++) begin
        wv  = $signed(w[c*ELEM_W +: ELEM_W]);
        acc = acc + x_m[r][c] * wv;
      end
      if (acc > Z_HI) begin
        acc = Z_HI;
      end else if (acc < Z_LO) begin
        acc = Z_LO;
      end
      res[r*Z_W +: Z_W] = acc[Z_W-1:0];
    end
    return res;
  endfunction

  task automatic report_error(input string msg);
    $display("test %s, cycle %0d: %s", cur_test, cyc, msg);
    test_errs++;
    total_errs++;
  endtask

  task automatic report_mismatch(input string what, input logic exp_b, input logic act_b);
    $display("mismatch in test %s, %s at cycle %0d: expected %b, actual %b",
             cur_test, what, cyc, exp_b, act_b);
    test_errs++;
    total_errs++;
  endtask

  task automatic clear_expected();
    exp_z_q.delete();
    exp_cyc_q.delete();
    exp_last_q.delete();
  endtask

  task automatic reset_model();
    for (int r = 0; r < ROWS; r++) begin
      y_m[r] = 0;
      for (int c = 0; c < COLS; c++) begin
        x_m[r][c] = 0;
      end
    end
    busy_m = 1'b0;
    len_m  = 0;
    cnt_m  = 0;
    clear_expected();
  endtask

  task automatic check_outputs(output bit last_seen);
    logic [ZV_W-1:0] ez;
    int              ecyc;
    bit              elast;
    last_seen = 1'b0;
    if (busy_i !== busy_m) begin
      report_mismatch("busy", busy_m, busy_i);
    end
    if (z_valid_i === 1'b1) begin
      if (exp_z_q.size() == 0) begin
        report_error("Z vector without an accepted W vector");
      end else begin
        ez    = exp_z_q.pop_front();
        ecyc  = exp_cyc_q.pop_front();
        elast = exp_last_q.pop_front();
        test_z++;
        total_z++;
        if (ecyc != cyc) begin
          report_error($sformatf("Z vector came at cycle %0d, expected at %0d", cyc, ecyc));
        end
        for (int r = 0; r < ROWS; r++) begin
          if (z_vec_i[r*Z_W +: Z_W] !== ez[r*Z_W +: Z_W]) begin
            $display("mismatch in test %s, row %0d at cycle %0d: expected %0d, actual %0d",
                     cur_test, r, cyc, $signed(ez[r*Z_W +: Z_W]),
                     $signed(z_vec_i[r*Z_W +: Z_W]));
            test_errs++;
            total_errs++;
          end
        end
        if (evt_i !== elast) begin
          report_mismatch("evt with this Z vector", elast, evt_i);
        end
        last_seen = elast;
      end
    end else begin
      if (z_valid_i !== 1'b0) begin
        report_error("z_valid is unknown");
      end
      if (evt_i !== 1'b0) begin
        report_error("evt raised without a Z vector");
      end
      if (exp_cyc_q.size() > 0 && exp_cyc_q[0] < cyc) begin
        report_error($sformatf("Z vector due at cycle %0d never came", exp_cyc_q[0]));
        void'(exp_z_q.pop_front());
        void'(exp_cyc_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
  endtask

  // Register writes count only while idle, W vectors only while busy
  task automatic update_model();
    int xa;
    int ya;
    bit was_busy;
    was_busy = busy_m;
    xa = int'(cfg_addr_i) - int'(REG_X_BASE);
    ya = int'(cfg_addr_i) - int'(REG_Y_BASE);
    if (cfg_valid_i === 1'b1 && !was_busy) begin
      if (xa >= 0 && xa < ROWS * COLS) begin
        x_m[xa / COLS][xa % COLS] = $signed(cfg_data_i[ELEM_W-1:0]);
      end else if (ya >= 0 && ya < ROWS) begin
        y_m[ya] = $signed(cfg_data_i[BIAS_W-1:0]);
      end else if (cfg_addr_i == REG_START && cfg_data_i[7:0] != 8'h00) begin
        busy_m = 1'b1;
        len_m  = cfg_data_i[7:0];
        cnt_m  = 0;
      end
    end
    if (w_valid_i === 1'b1 && was_busy && cnt_m < len_m) begin
      exp_z_q.push_back(expect_z(w_vec_i));
      exp_cyc_q.push_back(cyc + LATENCY);
      exp_last_q.push_back(cnt_m + 1 == len_m);
      cnt_m++;
    end
  endtask

  always @(posedge clk_i) begin
    cyc++;
    if (rst_i === 1'b1) begin
      // Registers hold unknown values until the first reset edge
      if (rst_cyc > 0 && (busy_i !== 1'b0 || z_valid_i !== 1'b0 || evt_i !== 1'b0)) begin
        report_error("outputs active during reset");
      end
      rst_cyc++;
      reset_model();
    end else begin
      check_outputs(job_over);
      update_model();
      if (job_over) begin
        busy_m = 1'b0;
      end
    end
  end

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
    test_z    = 0;
  endtask

  task automatic finish_test();
    if (exp_z_q.size() != 0) begin
      report_error($sformatf("%0d expected Z vectors never came", exp_z_q.size()));
      clear_expected();
    end
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s passed, %0d Z vectors checked", cur_test, test_z);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic print_summary();
    $display("%0d tests run, %0d failed, %0d Z vectors checked, %0d errors",
             tests_run, tests_failed, total_z, total_errs);
  endtask

endmodule : redmule_checker

// File: testbench/redmule_tb.sv
// ============================================================
// Testbench top: DUT, reset, xorshift stimulus, watchdog
// ============================================================
`timescale 1ns/1ps

module redmule_tb;
  import redmule_pkg::*;
  import redmule_cfg_pkg::*;

  localparam int ROWS         = ARRAY_WIDTH;
  localparam int COLS         = ARRAY_HEIGHT;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_JOBS    = 6;
  localparam int NUM_JOBS     = RAND_JOBS + 4;

  logic             clk;
  logic             rst;
  logic             cfg_valid;
  cfg_addr_t        cfg_addr;
  cfg_data_t        cfg_data;
  logic             w_valid;
  elem_t [COLS-1:0] w_vec;
  logic             z_valid;
  z_t [ROWS-1:0]    z_vec;
  logic             evt;
  logic             busy;
  int               err_cnt;

  logic [31:0] rng_state = 32'hee2d7d77;
  int          job_lens [NUM_JOBS];
  int          wd_limit;

  tb_clock u_clock (
    .clk_o ( clk )
  );

  redmule_top DUT (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .cfg_valid_i ( cfg_valid ),
    .cfg_addr_i  ( cfg_addr  ),
    .cfg_data_i  ( cfg_data  ),
    .w_valid_i   ( w_valid   ),
    .w_vec_i     ( w_vec     ),
    .z_valid_o   ( z_valid   ),
    .z_vec_o     ( z_vec     ),
    .evt_o       ( evt       ),
    .busy_o      ( busy      )
  );

  redmule_checker u_checker (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .cfg_valid_i ( cfg_valid ),
    .cfg_addr_i  ( cfg_addr  ),
    .cfg_data_i  ( cfg_data  ),
    .w_valid_i   ( w_valid   ),
    .w_vec_i     ( w_vec     ),
    .z_valid_i   ( z_valid   ),
    .z_vec_i     ( z_vec     ),
    .evt_i       ( evt       ),
    .busy_i      ( busy      ),
    .err_cnt_o   ( err_cnt   )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [COLS*ELEM_W-1:0] random_w();
    logic [COLS*ELEM_W-1:0] v;
    logic [31:0]            r;
    for (int c = 0; c < COLS; c++) begin
      r = rand32();
      v[c*ELEM_W +: ELEM_W] = r[ELEM_W-1:0];
    end
    return v;
  endfunction

  // Every element is either -128 or 127
  function automatic logic [COLS*ELEM_W-1:0] extreme_w();
    logic [COLS*ELEM_W-1:0] v;
    logic [31:0]            r;
    r = rand32();
    for (int c = 0; c < COLS; c++) begin
      v[c*ELEM_W +: ELEM_W] = r[c] ? 8'h7f : 8'h80;
    end
    return v;
  endfunction

  // Tasks start and end on a falling edge, strobes last one cycle
  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    cfg_valid = 1'b1;
    cfg_addr  = addr;
    cfg_data  = data;
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic send_w(input logic [COLS*ELEM_W-1:0] vec, input int gap);
    w_valid = 1'b1;
    w_vec   = vec;
    @(negedge clk);
    w_valid   = 1'b0;
    cfg_valid = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  task automatic load_random_tile();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        cfg_write(cfg_addr_t'(REG_X_BASE + r * COLS + c), rand32());
      end
      cfg_write(cfg_addr_t'(REG_Y_BASE + r), rand32());
    end
  endtask

  // Alternating +127 and -128 rows with full-scale biases
  task automatic load_extreme_tile();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        cfg_write(cfg_addr_t'(REG_X_BASE + r * COLS + c), (r % 2 == 0) ? 32'h7f : 32'h80);
      end
      cfg_write(cfg_addr_t'(REG_Y_BASE + r), (r == 0 || r == 3) ? 32'h7fff : 32'h8000);
    end
  endtask

  task automatic wait_job_end();
    while (busy !== 1'b0) @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  task automatic run_job(input int len, input bit extreme);
    int gap;
    cfg_write(REG_START, cfg_data_t'(len));
    for (int i = 0; i < len; i++) begin
      gap = rand32() % 3;
      send_w(extreme ? extreme_w() : random_w(), gap);
    end
    wait_job_end();
  endtask

  // Watchdog sized from the summed job lengths
  initial begin
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", wd_limit);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    logic [31:0] r;
    int          len_sum;
    rst       = 1'b1;
    cfg_valid = 1'b0;
    cfg_addr  = '0;
    cfg_data  = '0;
    w_valid   = 1'b0;
    w_vec     = '0;
    len_sum   = 0;
    for (int j = 0; j < RAND_JOBS; j++) begin
      job_lens[j] = 1 + rand32() % 12;
    end
    job_lens[RAND_JOBS]     = 8;
    job_lens[RAND_JOBS + 1] = 3;
    job_lens[RAND_JOBS + 2] = 5;
    job_lens[RAND_JOBS + 3] = 2;
    for (int j = 0; j < NUM_JOBS; j++) begin
      len_sum += job_lens[j];
    end
    wd_limit = len_sum * 10 + 200;

    u_checker.start_test("reset");
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    u_checker.finish_test();

    u_checker.start_test("random_jobs");
    for (int j = 0; j < RAND_JOBS; j++) begin
      load_random_tile();
      run_job(job_lens[j], 1'b0);
    end
    u_checker.finish_test();

    u_checker.start_test("saturation");
    load_extreme_tile();
    run_job(job_lens[RAND_JOBS], 1'b1);
    u_checker.finish_test();

    // Twice the count of back-to-back strobes
    u_checker.start_test("job_end");
    cfg_write(REG_START, cfg_data_t'(job_lens[RAND_JOBS + 1]));
    for (int i = 0; i < 2 * job_lens[RAND_JOBS + 1]; i++) begin
      send_w(random_w(), 0);
    end
    wait_job_end();
    u_checker.finish_test();

    u_checker.start_test("ignored_inputs");
    for (int i = 0; i < 3; i++) begin
      send_w(random_w(), 1);
    end
    cfg_write(8'h10, rand32());
    cfg_write(8'h50, rand32());
    cfg_write(8'hff, rand32());
    // Zero in the count byte
    cfg_write(REG_START, 32'h0000_0100);
    repeat (4) @(negedge clk);
    cfg_write(REG_START, cfg_data_t'(job_lens[RAND_JOBS + 2]));
    for (int i = 0; i < job_lens[RAND_JOBS + 2]; i++) begin
      r         = rand32();
      cfg_valid = 1'b1;
      cfg_data  = rand32();
      if (i == 1) begin
        cfg_addr = REG_START;
      end else if (r[20]) begin
        cfg_addr = cfg_addr_t'(REG_Y_BASE + r % ROWS);
      end else begin
        cfg_addr = cfg_addr_t'(REG_X_BASE + (r >> 8) % (ROWS * COLS));
      end
      send_w(random_w(), 0);
    end
    wait_job_end();
    run_job(job_lens[RAND_JOBS + 3], 1'b0);
    u_checker.finish_test();

    u_checker.print_summary();
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : redmule_tb

// File: sim.f
hw/redmule_pkg.sv
hw/redmule_cfg_pkg.sv
hw/redmule_decoder.sv
hw/redmule_row.sv
hw/redmule_engine.sv
hw/redmule_z_buffer.sv
hw/redmule_top.sv
testbench/tb_clock.sv
testbench/redmule_checker.sv
testbench/redmule_tb.sv
